// ==== common/pbch_pkg.sv ====
package pbch_pkg;

    // one OFDM symbol
    localparam int NFFT = 8;
    localparam int FFT_LEN = 2 ** NFFT;

    // PBCH DMRS sits on every fourth subcarrier
    localparam int PILOT_SPACING = 4;
    localparam int PILOTS_PER_SYM = FFT_LEN / PILOT_SPACING;
    localparam int PILOT_AW = $clog2(PILOTS_PER_SYM);
    localparam int OFFSET_W = $clog2(PILOT_SPACING);

    // candidate DMRS sequences, one per ibar_SSB value
    localparam int NUM_IBAR = 8;

    // length-31 Gold sequence of TS 38.211 5.2.1
    localparam int GOLD_N = 31;
    localparam int GOLD_SKIP = 1600;
    localparam logic [GOLD_N-1:0] X1_INIT = GOLD_N'(1);

    // cell ids go up to 1007
    localparam int NID_W = 10;

    // 64 pilots with two bits each give a range of +-128
    localparam int CORR_W = $clog2(2 * PILOTS_PER_SYM) + 2;

    typedef logic [$clog2(NUM_IBAR)-1:0] ibar_t;

    // bit 1 is c(2m), bit 0 is c(2m+1)
    typedef logic [1:0] pilot_t;

endpackage

// ==== compile.f ====
+incdir+verification
common/pbch_pkg.sv
hw/gold_seq.sv
dmrs_gen/dmrs_table.sv
dmrs_gen/dmrs_gen.sv
ibar_det/pilot_corr.sv
ibar_det/ibar_select.sv
hw/pbch_ibar_top.sv
verification/tb_pbch_ibar.sv

// ==== dmrs_gen/dmrs_gen.sv ====
`timescale 1ns/1ns

module dmrs_gen (
    input  logic                             clk_i,
    input  logic                             reset_ni,
    input  logic [pbch_pkg::NID_W-1:0]       n_id_i,
    input  logic                             n_id_valid_i,
    output logic                             wr_en_o,
    output logic [pbch_pkg::PILOT_AW-1:0]    wr_addr_o,
    output logic                             wr_half_o,
    output logic [pbch_pkg::NUM_IBAR-1:0]    wr_bits_o,
    output logic [pbch_pkg::OFFSET_W-1:0]    pilot_offset_o,
    output logic                             dmrs_ready_o
);
    import pbch_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_SKIP,
        ST_FILL
    } state_t;

    state_t state;
    logic [$clog2(GOLD_SKIP)-1:0] cnt;
    logic [GOLD_N-1:0] x1;
    logic load;
    logic step;

    assign load = (state == ST_LOAD);
    assign step = (state == ST_SKIP) || (state == ST_FILL);

    // fill output n lands in pair n/2, even n in bit 1
    assign wr_en_o = (state == ST_FILL);
    assign wr_addr_o = cnt[PILOT_AW:1];
    assign wr_half_o = cnt[0];

    // x1 is common to all eight candidates
    always_ff @(posedge clk_i) begin
        if (!reset_ni || load) begin
            x1 <= X1_INIT;
        end else if (step) begin
            x1 <= {x1[3] ^ x1[0], x1[GOLD_N-1:1]};
        end
    end

    for (genvar g = 0; g < NUM_IBAR; g++) begin : g_gold
        gold_seq #(
            .IBAR(ibar_t'(g))
        ) gold_seq_i (
            .clk_i(clk_i),
            .reset_ni(reset_ni),
            .n_id_i(n_id_i),
            .n_id_valid_i(n_id_valid_i),
            .load_i(load),
            .step_i(step),
            .x1_bit_i(x1[0]),
            .c_bit_o(wr_bits_o[g])
        );
    end

    // a new cell id restarts generation from any state
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state <= ST_IDLE;
            cnt <= '0;
            dmrs_ready_o <= 1'b0;
            pilot_offset_o <= '0;
        end else if (n_id_valid_i) begin
            state <= ST_LOAD;
            cnt <= '0;
            dmrs_ready_o <= 1'b0;
            pilot_offset_o <= n_id_i[OFFSET_W-1:0];
        end else begin
            case (state)
                ST_LOAD: state <= ST_SKIP;
                ST_SKIP: begin
                    if (cnt == GOLD_SKIP - 1) begin
                        cnt <= '0;
                        state <= ST_FILL;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                ST_FILL: begin
                    if (cnt == 2 * PILOTS_PER_SYM - 1) begin
                        cnt <= '0;
                        state <= ST_IDLE;
                        dmrs_ready_o <= 1'b1;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // the table is never written while the detector may read it
    assert property (@(posedge clk_i) disable iff (!reset_ni)
        wr_en_o |-> !dmrs_ready_o);

    // ready comes right after the write of the last bit
    assert property (@(posedge clk_i) disable iff (!reset_ni)
        $rose(dmrs_ready_o) |->
            $past(wr_en_o && wr_half_o && (wr_addr_o == PILOT_AW'(PILOTS_PER_SYM - 1))));

endmodule

// ==== dmrs_gen/dmrs_table.sv ====
`timescale 1ns/1ns

module dmrs_table (
    input  logic                             clk_i,
    input  logic                             wr_en_i,
    input  logic [pbch_pkg::PILOT_AW-1:0]    wr_addr_i,
    input  logic                             wr_half_i,
    input  logic [pbch_pkg::NUM_IBAR-1:0]    wr_bits_i,
    input  logic [pbch_pkg::PILOT_AW-1:0]    rd_addr_i,
    output pbch_pkg::pilot_t                 rd_pairs_o [pbch_pkg::NUM_IBAR]
);
    import pbch_pkg::*;

    pilot_t mem [NUM_IBAR][PILOTS_PER_SYM];

    // one generator bit per write for every candidate
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            for (int i = 0; i < NUM_IBAR; i++) begin
                if (wr_half_i) begin
                    mem[i][wr_addr_i][0] <= wr_bits_i[i];
                end else begin
                    mem[i][wr_addr_i][1] <= wr_bits_i[i];
                end
            end
        end
    end

    // all eight candidates come back together
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < NUM_IBAR; i++) begin
            rd_pairs_o[i] <= mem[i][rd_addr_i];
        end
    end

endmodule

// ==== hw/gold_seq.sv ====
`timescale 1ns/1ns

module gold_seq #(
    parameter pbch_pkg::ibar_t IBAR = '0
) (
    input  logic                          clk_i,
    input  logic                          reset_ni,
    input  logic [pbch_pkg::NID_W-1:0]    n_id_i,
    input  logic                          n_id_valid_i,
    input  logic                          load_i,
    input  logic                          step_i,
    input  logic                          x1_bit_i,
    output logic                          c_bit_o
);
    import pbch_pkg::*;

    localparam int unsigned IBAR_P1 = int'(IBAR) + 1;

    logic [GOLD_N-1:0] c_init;
    // x2[k] holds x2(n+k), so bit 0 is the current output
    logic [GOLD_N-1:0] x2;

    // c_init for PBCH DMRS, 38.211 7.4.1.4.1
    always_ff @(posedge clk_i) begin
        if (n_id_valid_i) begin
            c_init <= GOLD_N'(((IBAR_P1 * (n_id_i[NID_W-1:2] + 1)) << 11)
                              + (IBAR_P1 << 6) + n_id_i[1:0]);
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            x2 <= '0;
        end else if (load_i) begin
            x2 <= c_init;
        end else if (step_i) begin
            // x2(n+31) = x2(n+3) ^ x2(n+2) ^ x2(n+1) ^ x2(n)
            x2 <= {x2[3] ^ x2[2] ^ x2[1] ^ x2[0], x2[GOLD_N-1:1]};
        end
    end

    assign c_bit_o = x2[0] ^ x1_bit_i;

endmodule

// ==== hw/pbch_ibar_top.sv ====
`timescale 1ns/1ns

module pbch_ibar_top #(
    parameter int IN_DW = 32
) (
    input  logic                          clk_i,
    input  logic                          reset_ni,
    input  logic [pbch_pkg::NID_W-1:0]    n_id_i,
    input  logic                          n_id_valid_i,
    input  logic [IN_DW-1:0]              sample_i,
    input  logic                          sample_valid_i,
    input  logic                          pbch_start_i,
    output logic                          dmrs_ready_o,
    output pbch_pkg::ibar_t               ibar_o,
    output logic                          ibar_valid_o
);
    import pbch_pkg::*;

    logic wr_en;
    logic wr_half;
    logic [PILOT_AW-1:0] wr_addr;
    logic [PILOT_AW-1:0] rd_addr;
    logic [NUM_IBAR-1:0] wr_bits;
    logic [OFFSET_W-1:0] pilot_offset;
    logic dmrs_ready;
    logic corr_done;
    pilot_t rd_pairs [NUM_IBAR];
    logic signed [CORR_W-1:0] corr [NUM_IBAR];
    logic signed [CORR_W-1:0] corr_rot [NUM_IBAR];

    assign dmrs_ready_o = dmrs_ready;

    dmrs_gen dmrs_gen_i (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .n_id_i(n_id_i),
        .n_id_valid_i(n_id_valid_i),
        .wr_en_o(wr_en),
        .wr_addr_o(wr_addr),
        .wr_half_o(wr_half),
        .wr_bits_o(wr_bits),
        .pilot_offset_o(pilot_offset),
        .dmrs_ready_o(dmrs_ready)
    );

    dmrs_table dmrs_table_i (
        .clk_i(clk_i),
        .wr_en_i(wr_en),
        .wr_addr_i(wr_addr),
        .wr_half_i(wr_half),
        .wr_bits_i(wr_bits),
        .rd_addr_i(rd_addr),
        .rd_pairs_o(rd_pairs)
    );

    pilot_corr #(
        .IN_DW(IN_DW)
    ) pilot_corr_i (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .sample_i(sample_i),
        .sample_valid_i(sample_valid_i),
        .pbch_start_i(pbch_start_i),
        .dmrs_ready_i(dmrs_ready),
        .pilot_offset_i(pilot_offset),
        .rd_pairs_i(rd_pairs),
        .rd_addr_o(rd_addr),
        .corr_o(corr),
        .corr_rot_o(corr_rot),
        .corr_done_o(corr_done)
    );

    ibar_select ibar_select_i (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .corr_done_i(corr_done),
        .corr_i(corr),
        .corr_rot_i(corr_rot),
        .ibar_o(ibar_o),
        .ibar_valid_o(ibar_valid_o)
    );

endmodule

// ==== ibar_det/ibar_select.sv ====
`timescale 1ns/1ns

module ibar_select (
    input  logic                                clk_i,
    input  logic                                reset_ni,
    input  logic                                corr_done_i,
    input  logic signed [pbch_pkg::CORR_W-1:0]  corr_i [pbch_pkg::NUM_IBAR],
    input  logic signed [pbch_pkg::CORR_W-1:0]  corr_rot_i [pbch_pkg::NUM_IBAR],
    output pbch_pkg::ibar_t                     ibar_o,
    output logic                                ibar_valid_o
);
    import pbch_pkg::*;

    localparam int MAG_W = CORR_W - 1;

    logic [MAG_W-1:0] score_q [NUM_IBAR];
    logic [MAG_W-1:0] best_q;
    ibar_t idx_q, best_idx_q, next_idx;
    logic busy_q, better;

    function automatic logic [MAG_W-1:0] mag(logic signed [CORR_W-1:0] v);
        logic signed [CORR_W-1:0] a;
        a = (v < 0) ? -v : v;
        return a[MAG_W-1:0];
    endfunction

    // snapshot the scores so the correlators may clear for the next symbol
    always_ff @(posedge clk_i) begin
        if (corr_done_i) begin
            for (int i = 0; i < NUM_IBAR; i++) begin
                score_q[i] <= (mag(corr_rot_i[i]) > mag(corr_i[i])) ?
                              mag(corr_rot_i[i]) : mag(corr_i[i]);
            end
        end
    end

    // strict compare keeps the lowest index on a tie
    assign better = score_q[idx_q] > best_q;
    assign next_idx = better ? idx_q : best_idx_q;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            busy_q <= 1'b0;
            idx_q <= '0;
            best_q <= '0;
            best_idx_q <= '0;
            ibar_o <= '0;
            ibar_valid_o <= 1'b0;
        end else begin
            ibar_valid_o <= 1'b0;
            if (corr_done_i) begin
                busy_q <= 1'b1;
                idx_q <= '0;
                best_q <= '0;
                best_idx_q <= '0;
            end else if (busy_q) begin
                if (better) begin
                    best_q <= score_q[idx_q];
                end
                best_idx_q <= next_idx;
                idx_q <= idx_q + 1'b1;
                if (idx_q == ibar_t'(NUM_IBAR - 1)) begin
                    busy_q <= 1'b0;
                    ibar_o <= next_idx;
                    ibar_valid_o <= 1'b1;
                end
            end
        end
    end

    assert property (@(posedge clk_i) disable iff (!reset_ni)
        ibar_valid_o |=> !ibar_valid_o);

    // fixed latency from the end of correlation to the decision
    assert property (@(posedge clk_i) disable iff (!reset_ni)
        corr_done_i |-> ##(NUM_IBAR + 1) ibar_valid_o);

endmodule

// ==== ibar_det/pilot_corr.sv ====
`timescale 1ns/1ns

module pilot_corr #(
    parameter int IN_DW = 32
) (
    input  logic                                    clk_i,
    input  logic                                    reset_ni,
    input  logic [IN_DW-1:0]                        sample_i,
    input  logic                                    sample_valid_i,
    input  logic                                    pbch_start_i,
    input  logic                                    dmrs_ready_i,
    input  logic [pbch_pkg::OFFSET_W-1:0]           pilot_offset_i,
    input  pbch_pkg::pilot_t                        rd_pairs_i [pbch_pkg::NUM_IBAR],
    output logic [pbch_pkg::PILOT_AW-1:0]           rd_addr_o,
    output logic signed [pbch_pkg::CORR_W-1:0]      corr_o [pbch_pkg::NUM_IBAR],
    output logic signed [pbch_pkg::CORR_W-1:0]      corr_rot_o [pbch_pkg::NUM_IBAR],
    output logic                                    corr_done_o
);
    import pbch_pkg::*;

    localparam int HALF = IN_DW / 2;

    logic sym_open, last_q, pil_v;
    logic start_acc, take, is_pilot;
    logic [NFFT-1:0] sc_cnt, sc_idx;
    logic [OFFSET_W-1:0] offset_q, cur_offset, sc_rel;
    logic [PILOT_AW:0] pilot_cnt, pil_idx;
    logic re_neg, im_neg;
    pilot_t demod_q, demod_rot_q;

    // +1 per matching bit, -1 per differing bit
    function automatic logic signed [CORR_W-1:0] pair_score(pilot_t exp_p, pilot_t rx_p);
        logic [1:0] hit;
        hit = ~(exp_p ^ rx_p);
        case (hit)
            2'b11: return CORR_W'(2);
            2'b00: return -CORR_W'(2);
            default: return '0;
        endcase
    endfunction

    // the sample arriving with the start pulse is subcarrier 0
    // last_q keeps the final accumulation apart from the next clear
    assign start_acc = pbch_start_i && dmrs_ready_i && !sym_open && !last_q;
    assign take = sample_valid_i && (sym_open || start_acc);
    assign sc_idx = sym_open ? sc_cnt : '0;
    assign cur_offset = sym_open ? offset_q : pilot_offset_i;
    assign sc_rel = sc_idx[OFFSET_W-1:0] - cur_offset;
    assign is_pilot = (sc_rel == '0);

    assign pil_idx = start_acc ? '0 : pilot_cnt;
    assign rd_addr_o = pil_idx[PILOT_AW-1:0];

    assign re_neg = sample_i[HALF-1];
    assign im_neg = sample_i[IN_DW-1];

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            sym_open <= 1'b0;
            sc_cnt <= '0;
            pilot_cnt <= '0;
            offset_q <= '0;
            pil_v <= 1'b0;
            last_q <= 1'b0;
            corr_done_o <= 1'b0;
        end else begin
            pil_v <= take && is_pilot;
            last_q <= take && (sc_idx == NFFT'(FFT_LEN - 1));
            corr_done_o <= last_q;
            if (start_acc) begin
                sym_open <= 1'b1;
                offset_q <= pilot_offset_i;
                pilot_cnt <= '0;
                sc_cnt <= '0;
            end
            if (take) begin
                sc_cnt <= sc_idx + 1'b1;
                if (is_pilot) begin
                    pilot_cnt <= pil_idx + 1'b1;
                end
                if (sc_idx == NFFT'(FFT_LEN - 1)) begin
                    sym_open <= 1'b0;
                end
            end
        end
    end

    // hard BPSK decision, plain and turned by 90 degrees
    always_ff @(posedge clk_i) begin
        if (take) begin
            demod_q <= {re_neg, im_neg};
            demod_rot_q <= {~im_neg, re_neg};
        end
    end

    // table pairs arrive together with pil_v
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < NUM_IBAR; i++) begin
            if (start_acc) begin
                corr_o[i] <= '0;
                corr_rot_o[i] <= '0;
            end else if (pil_v) begin
                corr_o[i] <= corr_o[i] + pair_score(rd_pairs_i[i], demod_q);
                corr_rot_o[i] <= corr_rot_o[i] + pair_score(rd_pairs_i[i], demod_rot_q);
            end
        end
    end

    // framing must never ask for more pilots than one symbol carries
    assert property (@(posedge clk_i) disable iff (!reset_ni)
        (take && is_pilot) |-> (pil_idx < PILOTS_PER_SYM));

endmodule

// ==== verification/tb_ref.svh ====
`ifndef TB_REF_SVH
`define TB_REF_SVH

// reference models, IN_DW comes from the including module

// Galois LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
        return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
endfunction

// c_init of the PBCH DMRS, 38.211 7.4.1.4.1
function automatic int dmrs_c_init(input int ibar, input int n_id);
    return 2048 * (ibar + 1) * (n_id / 4 + 1) + 64 * (ibar + 1) + n_id % 4;
endfunction

// bit n of the result is c(n), the first GOLD_SKIP outputs dropped
function automatic logic [2*PILOTS_PER_SYM-1:0] gold_bits(input logic [31:0] c_init);
    logic x1 [GOLD_SKIP + 2 * PILOTS_PER_SYM + GOLD_N];
    logic x2 [GOLD_SKIP + 2 * PILOTS_PER_SYM + GOLD_N];
    logic [2*PILOTS_PER_SYM-1:0] c;
    for (int n = 0; n < GOLD_N; n++) begin
        x1[n] = (n == 0);
        x2[n] = c_init[n];
    end
    for (int n = 0; n < GOLD_SKIP + 2 * PILOTS_PER_SYM; n++) begin
        x1[n + GOLD_N] = x1[n + 3] ^ x1[n];
        x2[n + GOLD_N] = x2[n + 3] ^ x2[n + 2] ^ x2[n + 1] ^ x2[n];
    end
    for (int n = 0; n < 2 * PILOTS_PER_SYM; n++) begin
        c[n] = x1[n + GOLD_SKIP] ^ x2[n + GOLD_SKIP];
    end
    return c;
endfunction

// hard demod of the pilots, +-1 per bit, best of plain and rotated magnitude
function automatic int expected_ibar(input logic [FFT_LEN*IN_DW-1:0] sym, input int offset,
                                     input logic [NUM_IBAR*2*PILOTS_PER_SYM-1:0] tab);
    int corr [NUM_IBAR];
    int corr_rot [NUM_IBAR];
    int m;
    int score;
    int best;
    int best_idx;
    logic [IN_DW-1:0] s;
    logic re_neg;
    logic im_neg;
    logic [1:0] plain;
    logic [1:0] rot;
    logic [1:0] exp_pair;
    for (int i = 0; i < NUM_IBAR; i++) begin
        corr[i] = 0;
        corr_rot[i] = 0;
    end
    m = 0;
    for (int sc = 0; sc < FFT_LEN; sc++) begin
        if (sc % PILOT_SPACING == offset) begin
            s = sym[sc*IN_DW +: IN_DW];
            re_neg = s[IN_DW/2-1];
            im_neg = s[IN_DW-1];
            plain = {re_neg, im_neg};
            rot = {~im_neg, re_neg};
            for (int i = 0; i < NUM_IBAR; i++) begin
                exp_pair = {tab[i*2*PILOTS_PER_SYM + 2*m], tab[i*2*PILOTS_PER_SYM + 2*m + 1]};
                for (int b = 0; b < 2; b++) begin
                    corr[i] += (plain[b] == exp_pair[b]) ? 1 : -1;
                    corr_rot[i] += (rot[b] == exp_pair[b]) ? 1 : -1;
                end
            end
            m++;
        end
    end
    best = -1;
    best_idx = 0;
    for (int i = 0; i < NUM_IBAR; i++) begin
        score = (corr[i] < 0) ? -corr[i] : corr[i];
        if (corr_rot[i] > score || -corr_rot[i] > score) begin
            score = (corr_rot[i] < 0) ? -corr_rot[i] : corr_rot[i];
        end
        // ties stay with the lower index
        if (score > best) begin
            best = score;
            best_idx = i;
        end
    end
    return best_idx;
endfunction

`endif

// ==== verification/tb_pbch_ibar.sv ====
`timescale 1ns/1ns

module tb_pbch_ibar;
    import pbch_pkg::*;

    localparam int IN_DW = 32;
    localparam int HALF = IN_DW / 2;
    localparam int SEQ_LEN = 2 * PILOTS_PER_SYM;
    localparam int NUM_SYMBOLS = 33;
    localparam int MAX_GAP = 3;
    localparam int READY_CYCLES = GOLD_SKIP + 2 * PILOTS_PER_SYM + 2;

    `include "tb_ref.svh"

    logic clk_i;
    logic reset_ni;
    logic [NID_W-1:0] n_id_i;
    logic n_id_valid_i;
    logic [IN_DW-1:0] sample_i;
    logic sample_valid_i;
    logic pbch_start_i;
    logic dmrs_ready_o;
    ibar_t ibar_o;
    logic ibar_valid_o;

    logic [31:0] lfsr_state;
    logic [FFT_LEN*IN_DW-1:0] sym_flat;
    logic [NUM_IBAR*SEQ_LEN-1:0] gold_tab;
    int offset;
    int exp_q [$];

    pbch_ibar_top #(
        .IN_DW(IN_DW)
    ) pbch_ibar_top_i (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .n_id_i(n_id_i),
        .n_id_valid_i(n_id_valid_i),
        .sample_i(sample_i),
        .sample_valid_i(sample_valid_i),
        .pbch_start_i(pbch_start_i),
        .dmrs_ready_o(dmrs_ready_o),
        .ibar_o(ibar_o),
        .ibar_valid_o(ibar_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    task automatic check_value(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("FAILED at %0t ns: %s, got %0d, expected %0d", $time, what, actual, expected);
            $display("Result: FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "run aborted");
    endtask

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // pilot bit 0 gives a positive amplitude and non-pilots carry noise
    task automatic build_symbol(input int ibar, input bit rotate);
        logic signed [HALF-1:0] re;
        logic signed [HALF-1:0] im;
        logic signed [HALF-1:0] tmp;
        logic signed [HALF-1:0] amp;
        int m;
        m = 0;
        for (int sc = 0; sc < FFT_LEN; sc++) begin
            if (sc % PILOT_SPACING == offset) begin
                amp = HALF'(1000) + HALF'(take_bits(8));
                re = gold_tab[ibar*SEQ_LEN + 2*m] ? -amp : amp;
                im = gold_tab[ibar*SEQ_LEN + 2*m + 1] ? -amp : amp;
                m++;
            end else begin
                re = HALF'(take_bits(HALF));
                im = HALF'(take_bits(HALF));
            end
            // 90 degrees means a multiply by j
            if (rotate) begin
                tmp = re;
                re = -im;
                im = tmp;
            end
            sym_flat[sc*IN_DW +: IN_DW] = {im, re};
        end
    endtask

    task automatic send_symbol(input bit gaps);
        int gap;
        @(posedge clk_i);
        #2;
        pbch_start_i = 1'b1;
        sample_valid_i = 1'b1;
        sample_i = sym_flat[0 +: IN_DW];
        for (int sc = 1; sc < FFT_LEN; sc++) begin
            @(posedge clk_i);
            #2;
            pbch_start_i = 1'b0;
            gap = gaps ? int'(take_bits(2)) : 0;
            repeat (gap) begin
                sample_valid_i = 1'b0;
                sample_i = take_bits(IN_DW);
                @(posedge clk_i);
                #2;
            end
            sample_valid_i = 1'b1;
            sample_i = sym_flat[sc*IN_DW +: IN_DW];
        end
        @(posedge clk_i);
        #2;
        pbch_start_i = 1'b0;
        sample_valid_i = 1'b0;
        sample_i = '0;
    endtask

    task automatic wait_for_ibar();
        int t;
        t = 0;
        while (exp_q.size() != 0) begin
            if (t > 2 * NUM_IBAR + 16) begin
                abort_run("ibar_valid_o did not arrive after the end of the symbol");
            end
            @(posedge clk_i);
            t++;
        end
        repeat (2) @(posedge clk_i);
    endtask

    task automatic run_symbol(input int ibar, input bit rotate, input bit gaps);
        int exp_ibar;
        build_symbol(ibar, rotate);
        exp_ibar = expected_ibar(sym_flat, offset, gold_tab);
        check_value(exp_ibar, ibar, "reference ibar against the transmitted one");
        exp_q.push_back(exp_ibar);
        send_symbol(gaps);
        wait_for_ibar();
    endtask

    task automatic load_cell_id(input int nid);
        int cycles;
        @(posedge clk_i);
        #2;
        n_id_i = NID_W'(nid);
        n_id_valid_i = 1'b1;
        @(posedge clk_i);
        #2;
        n_id_valid_i = 1'b0;
        cycles = 1;
        check_value(dmrs_ready_o, 0, "dmrs_ready_o right after n_id_valid_i");
        while (dmrs_ready_o !== 1'b1) begin
            if (cycles > 2 * READY_CYCLES) begin
                abort_run("dmrs_ready_o never rose after a cell id was loaded");
            end
            @(posedge clk_i);
            #2;
            cycles++;
        end
        check_value(cycles, READY_CYCLES, "cycles from n_id_valid_i to dmrs_ready_o");
        offset = nid % PILOT_SPACING;
        for (int i = 0; i < NUM_IBAR; i++) begin
            gold_tab[i*SEQ_LEN +: SEQ_LEN] = gold_bits(dmrs_c_init(i, nid));
        end
    endtask

    // every decision is matched against the queued expectation
    always @(negedge clk_i) begin : compare_ibar
        int exp_ibar;
        if (reset_ni === 1'b1 && ibar_valid_o === 1'b1) begin
            check_value(exp_q.size() > 0, 1, "ibar_valid_o with no symbol pending");
            exp_ibar = exp_q.pop_front();
            check_value(ibar_o, exp_ibar, "ibar_o");
        end
    end

    initial begin
        repeat (NUM_SYMBOLS * (FFT_LEN * (MAX_GAP + 1) + 64) + 4 * 1800) @(posedge clk_i);
        abort_run("timeout, the test sequence did not finish in time");
    end

    initial begin
        reset_ni = 1'b0;
        n_id_i = '0;
        n_id_valid_i = 1'b0;
        sample_i = '0;
        sample_valid_i = 1'b0;
        pbch_start_i = 1'b0;
        lfsr_state = 32'ha0bd6966;
        gold_tab = '0;
        offset = 0;
        repeat (3) @(posedge clk_i);
        #2;
        reset_ni = 1'b1;

        check_value(dmrs_ready_o, 0, "dmrs_ready_o after reset");
        check_value(ibar_valid_o, 0, "ibar_valid_o after reset");
        // without a table this symbol must be ignored
        build_symbol(0, 1'b0);
        send_symbol(1'b0);
        repeat (2 * NUM_IBAR + 16) @(posedge clk_i);

        load_cell_id(417);
        for (int i = 0; i < NUM_IBAR; i++) begin
            run_symbol(i, 1'b0, 1'b0);
        end
        for (int i = 0; i < NUM_IBAR; i++) begin
            run_symbol(i, 1'b1, 1'b0);
        end
        for (int i = 0; i < NUM_IBAR; i++) begin
            run_symbol(int'(take_bits(3)), 1'(take_bits(1)), 1'b1);
        end

        // new id with another pilot offset
        load_cell_id(1006);
        for (int i = 0; i < NUM_IBAR; i++) begin
            run_symbol(i, 1'(i % 2), i >= NUM_IBAR / 2);
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule
